/* compile.f */
common/nnPkg.sv
common/cmdIf.sv
decode/cmdDecoder.sv
execute/macEngine.sv
verilog/reluOutput.sv
verilog/neuralLayer.sv
test/tbClock.sv
test/tbChecker.sv
test/tbTop.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f compile.f --top-module neuralLayer
	verilator --lint-only --timing -f compile.f --top-module tbTop

sim:
	verilator --binary --timing --assert -f compile.f --top-module tbTop -Mdir obj_dir -o tbSim
	@out="$$(./obj_dir/tbSim)"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir

/* test/tbTop.sv */
`timescale 1ns/1ps

module tbTop
	import nnPkg::*;
;

	localparam int numInputs = 15;
	localparam int numNeurons = 4;
	localparam int indexBits = (numInputs > 1) ? $clog2(numInputs) : 1;
	localparam int neuronBits = (numNeurons > 1) ? $clog2(numNeurons) : 1;
	localparam int ackTimeout = 100;

	logic clk;
	logic reset;
	logic req;
	opcode_t opcode;
	logic [neuronBits-1:0] neuron;
	logic [indexBits-1:0] index;
	logic [dataWidth-1:0] data;
	logic ack;
	logic [dataWidth-1:0] result;

	logic [8*16-1:0] testName;
	logic [15:0] lfsrState = 16'd49;
	int errorCount;
	int errorsAtStart;
	int timeouts = 0;
	int timeoutsAtStart;
	int testsPassed = 0;
	int testsFailed = 0;

	tbClock i_clock (
		.clk(clk),
		.reset(reset)
	);

	neuralLayer #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.req(req),
		.opcode(opcode),
		.neuron(neuron),
		.index(index),
		.data(data),
		.ack(ack),
		.result(result)
	);

	tbChecker #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) i_checker (
		.clk(clk),
		.reset(reset),
		.req(req),
		.opcode(opcode),
		.neuron(neuron),
		.index(index),
		.data(data),
		.ack(ack),
		.result(result),
		.testName(testName),
		.errorCount(errorCount)
	);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
	function automatic logic [15:0] takeBits(input int count);
		logic [15:0] value;
		logic feedback;
		value = '0;
		for (int b = 0; b < count; b++)
		begin
			feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
			lfsrState = {lfsrState[14:0], feedback};
			value = {value[14:0], feedback};
		end
		return value;
	endfunction

	function automatic int randomIndex();
		return int'(takeBits(indexBits)) % numInputs;
	endfunction

	function automatic int randomHold();
		return int'(takeBits(5)) % 21;
	endfunction

	// one full four-phase transfer, req held extraHold cycles past ack
	task automatic sendCommand(input opcode_t op, input int n, input int idx,
		input logic [dataWidth-1:0] value, input int extraHold);
		int waited;
		@(negedge clk);
		opcode = op;
		neuron = neuronBits'(n);
		index = indexBits'(idx);
		data = value;
		req = 1'b1;
		waited = 0;
		while (!ack && waited < ackTimeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (!ack)
		begin
			$display("timeout waiting for ack to rise in test %0s", testName);
			timeouts++;
		end
		else
			repeat (extraHold) @(negedge clk);
		req = 1'b0;
		waited = 0;
		while (ack && waited < ackTimeout)
		begin
			@(negedge clk);
			waited++;
		end
		if (ack)
		begin
			$display("timeout waiting for ack to fall in test %0s", testName);
			timeouts++;
		end
	endtask

	task automatic beginTest(input logic [8*16-1:0] name);
		testName = name;
		errorsAtStart = errorCount;
		timeoutsAtStart = timeouts;
	endtask

	task automatic endTest();
		if (errorCount == errorsAtStart && timeouts == timeoutsAtStart)
		begin
			$display("test %0s passed", testName);
			testsPassed++;
		end
		else
		begin
			$display("test %0s failed", testName);
			testsFailed++;
		end
	endtask

	initial
	begin
		int waited;
		int n;
		req = 1'b0;
		opcode = OP_LOAD_ACT;
		neuron = '0;
		index = '0;
		data = '0;
		testName = "startup";

		waited = 0;
		@(negedge clk); // reset is settled here
		while (reset && waited < 20)
		begin
			@(negedge clk);
			waited++;
		end
		if (reset)
		begin
			$display("reset was never released");
			timeouts++;
		end

		beginTest("reset");
		@(negedge clk); // the checker looks at ack and result on this cycle
		sendCommand(OP_RUN, 0, 0, '0, 0); // empty storage sums to zero
		endTest();

		beginTest("random layer");
		for (int i = 0; i < numInputs; i++)
			sendCommand(OP_LOAD_ACT, 0, i, takeBits(16), 0);
		for (int k = 0; k < numNeurons; k++)
		begin
			for (int i = 0; i < numInputs; i++)
				sendCommand(OP_LOAD_WEIGHT, k, i, takeBits(16), 0);
			sendCommand(OP_LOAD_BIAS, k, 0, takeBits(16), 0);
		end
		for (int k = 0; k < numNeurons; k++)
			sendCommand(OP_RUN, k, 0, '0, 0);
		endTest();

		// small positive activations against negative weights push bit 15 high
		beginTest("relu clamp");
		for (int i = 0; i < numInputs; i++)
			sendCommand(OP_LOAD_ACT, 0, i, takeBits(4) + 16'd1, 0);
		for (int i = 0; i < numInputs; i++)
			sendCommand(OP_LOAD_WEIGHT, 2, i, 16'd0 - (takeBits(4) + 16'd1), 0);
		sendCommand(OP_LOAD_BIAS, 2, 0, '0, 0);
		sendCommand(OP_RUN, 2, 0, '0, 0);
		endTest();

		beginTest("persistence");
		sendCommand(OP_LOAD_ACT, 0, randomIndex(), takeBits(16), 0);
		for (int k = 0; k < numNeurons; k++)
			sendCommand(OP_RUN, k, 0, '0, 0);
		endTest();

		beginTest("handshake");
		for (int k = 0; k < numNeurons; k++)
			sendCommand(OP_RUN, k, 0, '0, randomHold());
		n = int'(takeBits(neuronBits));
		sendCommand(OP_LOAD_BIAS, n, 0, takeBits(16), randomHold());
		sendCommand(OP_LOAD_ACT, 0, randomIndex(), takeBits(16), randomHold());
		sendCommand(OP_RUN, n, 0, '0, randomHold());
		endTest();

		$display("tests passed %0d failed %0d", testsPassed, testsFailed);
		if (testsFailed == 0 && timeouts == 0 && errorCount == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* test/tbChecker.sv */
`timescale 1ns/1ps

module tbChecker
	import nnPkg::*;
#(
	parameter int numInputs = 15,
	parameter int numNeurons = 4,
	localparam int indexBits = (numInputs > 1) ? $clog2(numInputs) : 1,
	localparam int neuronBits = (numNeurons > 1) ? $clog2(numNeurons) : 1
)
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  opcode_t opcode,
	input  logic [neuronBits-1:0] neuron,
	input  logic [indexBits-1:0] index,
	input  logic [dataWidth-1:0] data,
	input  logic ack,
	input  logic [dataWidth-1:0] result,
	input  logic [8*16-1:0] testName,
	output int errorCount
);

	// mirror of the layer storage, rebuilt from the commands seen on the port
	logic [dataWidth-1:0] actModel [numInputs];
	logic [dataWidth-1:0] weightModel [numNeurons][numInputs];
	logic [dataWidth-1:0] biasModel [numNeurons];
	logic [dataWidth-1:0] heldResult;
	logic [dataWidth-1:0] expected;
	logic prevAck;
	logic prevReq;
	logic prevReset;
	logic runPending;

	// weighted sum plus bias, wrapped to 16 bits, negative sums give zero
	function automatic logic [dataWidth-1:0] expectedResult(input int n);
		logic [dataWidth-1:0] total;
		total = biasModel[n];
		for (int i = 0; i < numInputs; i++)
			total = total + actModel[i] * weightModel[n][i];
		if (total[dataWidth-1])
			return '0;
		return total;
	endfunction

	initial
	begin
		errorCount = 0;
		prevAck = 1'b0;
		prevReq = 1'b0;
		prevReset = 1'b1;
	end

	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numInputs; i++)
				actModel[i] = '0;
			for (int n = 0; n < numNeurons; n++)
			begin
				biasModel[n] = '0;
				for (int i = 0; i < numInputs; i++)
					weightModel[n][i] = '0;
			end
			heldResult = '0;
		end
		else
		begin
			if (prevReset && ack)
			begin
				$display("ack was high right after reset in test %0s", testName);
				errorCount++;
			end
			runPending = req && (opcode == OP_RUN) && !ack; // result may move here

			if (ack && !prevAck)
			begin
				// ack went up on the previous edge, so req is judged there
				if (!prevReq)
				begin
					$display("ack rose while req was low in test %0s", testName);
					errorCount++;
				end
				if (opcode == OP_RUN)
				begin
					expected = expectedResult(int'(neuron));
					if (result !== expected)
					begin
						$display("ERR %0s expected %h actual %h", testName, expected, result);
						errorCount++;
					end
					heldResult = result;
				end
				else
				begin
					if (result !== heldResult)
					begin
						$display("ERR %0s expected %h actual %h", testName, heldResult, result);
						errorCount++;
						heldResult = result;
					end
					case (opcode)
						OP_LOAD_ACT:    actModel[index] = data;
						OP_LOAD_WEIGHT: weightModel[neuron][index] = data;
						default:        biasModel[neuron] = data;
					endcase
				end
			end
			else if (!runPending && result !== heldResult)
			begin
				// result has to hold between runs, also while ack stays up
				$display("ERR %0s expected %h actual %h", testName, heldResult, result);
				errorCount++;
				heldResult = result;
			end

			if (prevAck && !ack && prevReq)
			begin
				$display("ack fell while req was still high in test %0s", testName);
				errorCount++;
			end
		end
		prevAck = ack;
		prevReq = req;
		prevReset = reset;
	end

endmodule

/* test/tbClock.sv */
`timescale 1ns/1ps

module tbClock
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// reset is sampled high on three rising edges, then released between edges
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* verilog/neuralLayer.sv */
`timescale 1ns/1ps

module neuralLayer
	import nnPkg::*;
#(
	parameter int numInputs = 15,
	parameter int numNeurons = 4,
	localparam int indexBits = (numInputs > 1) ? $clog2(numInputs) : 1,
	localparam int neuronBits = (numNeurons > 1) ? $clog2(numNeurons) : 1
)
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  opcode_t opcode,
	input  logic [neuronBits-1:0] neuron,
	input  logic [indexBits-1:0] index,
	input  logic [dataWidth-1:0] data,
	output logic ack,
	output logic [dataWidth-1:0] result
);

	logic sumValid;
	logic [dataWidth-1:0] sum;
	logic resultDone;

	cmdIf #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) i_cmd ();

	// handshake and storage writes
	cmdDecoder #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) i_decoder (
		.clk(clk),
		.reset(reset),
		.req(req),
		.opcode(opcode),
		.neuron(neuron),
		.index(index),
		.data(data),
		.ack(ack),
		.resultDone(resultDone),
		.cmd(i_cmd.decoder)
	);

	macEngine #(
		.numInputs(numInputs),
		.numNeurons(numNeurons)
	) i_engine (
		.clk(clk),
		.reset(reset),
		.cmd(i_cmd.engine),
		.sumValid(sumValid),
		.sum(sum)
	);

	reluOutput i_relu (
		.clk(clk),
		.reset(reset),
		.sumValid(sumValid),
		.sum(sum),
		.result(result),
		.resultDone(resultDone) // closes the loop back to the decoder
	);

endmodule

/* verilog/reluOutput.sv */
`timescale 1ns/1ps

module reluOutput
	import nnPkg::*;
(
	input  logic clk,
	input  logic reset,
	input  logic sumValid,
	input  logic [dataWidth-1:0] sum,
	output logic [dataWidth-1:0] result,
	output logic resultDone
);

	logic negative;

	// sign bit of the wrapped sum decides the clamp
	assign negative = sum[dataWidth-1];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			resultDone <= 1'b0;
		end
		else
		begin
			resultDone <= sumValid;
			if (sumValid)
			begin
				if (negative)
					result <= '0;
				else
					result <= sum;
			end
			// otherwise result holds until the next run
		end
	end

	donePulse: assert property (@(posedge clk) disable iff (reset)
		resultDone |=> !resultDone);

endmodule

/* execute/macEngine.sv */
`timescale 1ns/1ps

module macEngine
	import nnPkg::*;
#(
	parameter int numInputs = 15,
	parameter int numNeurons = 4,
	localparam int indexBits = (numInputs > 1) ? $clog2(numInputs) : 1,
	localparam int neuronBits = (numNeurons > 1) ? $clog2(numNeurons) : 1
)
(
	input  logic clk,
	input  logic reset,
	cmdIf.engine cmd,
	output logic sumValid,
	output logic [dataWidth-1:0] sum
);

	localparam logic [indexBits-1:0] lastIndex = indexBits'(numInputs - 1);

	// activations are shared by all neurons, weights and biases are per neuron
	logic [dataWidth-1:0] act [numInputs];
	logic [dataWidth-1:0] weight [numNeurons][numInputs];
	logic [dataWidth-1:0] bias [numNeurons];

	logic busy;
	logic [indexBits-1:0] macIdx;
	logic [neuronBits-1:0] runNeuron;
	logic [dataWidth-1:0] acc;
	logic [dataWidth-1:0] product;
	logic indexOk;
	logic neuronOk;

	// the product wraps to 16 bits just like the reference node
	assign product = act[macIdx] * weight[runNeuron][macIdx];

	assign indexOk = int'(cmd.index) < numInputs;
	assign neuronOk = int'(cmd.neuron) < numNeurons;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < numInputs; i++)
				act[i] <= '0;
			for (int n = 0; n < numNeurons; n++)
			begin
				bias[n] <= '0;
				for (int i = 0; i < numInputs; i++)
					weight[n][i] <= '0;
			end
		end
		else
		begin
			if (cmd.wrAct && indexOk)
				act[cmd.index] <= cmd.data;
			if (cmd.wrWeight && neuronOk && indexOk)
				weight[cmd.neuron][cmd.index] <= cmd.data;
			if (cmd.wrBias && neuronOk)
				bias[cmd.neuron] <= cmd.data;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			macIdx <= '0;
			sumValid <= 1'b0;
		end
		else
		begin
			sumValid <= 1'b0;
			if (cmd.start)
			begin
				busy <= 1'b1;
				macIdx <= '0;
				runNeuron <= cmd.neuron;
				acc <= '0;
			end
			else if (busy)
			begin
				if (macIdx == lastIndex)
				begin
					// the final product and the bias go in together
					sum <= acc + product + bias[runNeuron];
					sumValid <= 1'b1;
					busy <= 1'b0;
					macIdx <= '0;
				end
				else
				begin
					acc <= acc + product;
					macIdx <= macIdx + 1'b1;
				end
			end
		end
	end

	// the handshake keeps a second run out until the first has been acked
	noStartWhileBusy: assert property (@(posedge clk) disable iff (reset)
		cmd.start |-> !busy);

endmodule

/* decode/cmdDecoder.sv */
`timescale 1ns/1ps

module cmdDecoder
	import nnPkg::*;
#(
	parameter int numInputs = 15,
	parameter int numNeurons = 4,
	localparam int indexBits = (numInputs > 1) ? $clog2(numInputs) : 1,
	localparam int neuronBits = (numNeurons > 1) ? $clog2(numNeurons) : 1
)
(
	input  logic clk,
	input  logic reset,
	input  logic req,
	input  opcode_t opcode,
	input  logic [neuronBits-1:0] neuron,
	input  logic [indexBits-1:0] index,
	input  logic [dataWidth-1:0] data,
	output logic ack,
	input  logic resultDone,
	cmdIf.decoder cmd
);

	decodeState_t state;
	logic accept;

	// a new command is taken only from IDLE, so later opcode changes are ignored
	assign accept = (state == IDLE) && req;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= IDLE;
			ack <= 1'b0;
			cmd.wrAct <= 1'b0;
			cmd.wrWeight <= 1'b0;
			cmd.wrBias <= 1'b0;
			cmd.start <= 1'b0;
		end
		else
		begin
			// strobes drop again unless raised below
			cmd.wrAct <= 1'b0;
			cmd.wrWeight <= 1'b0;
			cmd.wrBias <= 1'b0;
			cmd.start <= 1'b0;

			case (state)
				IDLE:
				begin
					if (req)
					begin
						case (opcode)
							OP_LOAD_ACT:    cmd.wrAct <= 1'b1;
							OP_LOAD_WEIGHT: cmd.wrWeight <= 1'b1;
							OP_LOAD_BIAS:   cmd.wrBias <= 1'b1;
							default:        cmd.start <= 1'b1;
						endcase
						state <= (opcode == OP_RUN) ? WAIT_RESULT : ACK_HIGH;
					end
				end

				WAIT_RESULT:
				begin
					if (resultDone)
					begin
						ack <= 1'b1; // result is already registered at this point
						state <= WAIT_REQ_LOW;
					end
				end

				ACK_HIGH:
				begin
					// the write strobe lands in the engine on this edge
					ack <= 1'b1;
					state <= WAIT_REQ_LOW;
				end

				WAIT_REQ_LOW:
				begin
					if (!req)
					begin
						ack <= 1'b0;
						state <= IDLE;
					end
				end

				default: state <= IDLE;
			endcase
		end
	end

	// address and value follow the host while idle and freeze once accepted
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			cmd.neuron <= neuron;
			cmd.index <= index;
			cmd.data <= data;
		end
	end

	// the host must still be requesting when ack comes up
	ackNeedsReq: assert property (@(posedge clk) disable iff (reset)
		$rose(ack) |-> $past(req));

	strobesExclusive: assert property (@(posedge clk) disable iff (reset)
		$onehot0({cmd.wrAct, cmd.wrWeight, cmd.wrBias, cmd.start}));

endmodule

/* common/cmdIf.sv */
`timescale 1ns/1ps

interface cmdIf
	import nnPkg::*;
#(
	parameter int numInputs = 15,
	parameter int numNeurons = 4
);

	localparam int indexBits = (numInputs > 1) ? $clog2(numInputs) : 1;
	localparam int neuronBits = (numNeurons > 1) ? $clog2(numNeurons) : 1;

	// single-cycle strobes from the decoder
	logic wrAct;
	logic wrWeight;
	logic wrBias;
	logic start;

	// address and value, stable for the whole command
	logic [neuronBits-1:0] neuron;
	logic [indexBits-1:0] index;
	logic [dataWidth-1:0] data;

	modport decoder
	(
		output wrAct,
		output wrWeight,
		output wrBias,
		output start,
		output neuron,
		output index,
		output data
	);

	modport engine
	(
		input wrAct,
		input wrWeight,
		input wrBias,
		input start,
		input neuron,
		input index,
		input data
	);

endinterface

/* common/nnPkg.sv */
package nnPkg;

	// every activation, weight, bias, sum and result shares this width
	localparam int dataWidth = 16;

	// host command set, carried on the opcode port
	typedef enum logic [1:0]
	{
		OP_LOAD_ACT    = 2'd0, // activation at index
		OP_LOAD_WEIGHT = 2'd1, // weight at neuron and index
		OP_LOAD_BIAS   = 2'd2, // bias of neuron
		OP_RUN         = 2'd3  // evaluate one neuron
	} opcode_t;

	// states of the four-phase handshake controller
	typedef enum logic [1:0]
	{
		IDLE         = 2'd0,
		WAIT_RESULT  = 2'd1, // run launched, waiting for the output stage
		ACK_HIGH     = 2'd2, // load written, ack goes up next
		WAIT_REQ_LOW = 2'd3  // ack held until the host drops req
	} decodeState_t;

endpackage
